/* common/alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// ----------------------------------------------------------------------
// ALU datapath sizes
// ----------------------------------------------------------------------
`define ALU_WORD_WIDTH  16  // Operand and result width
`define ALU_SHAMT_WIDTH 4   // Shift amount taken from low bits of B
`define ALU_OP_WIDTH    4   // Opcode field in the control word

// ----------------------------------------------------------------------
// APB bus sizes
// ----------------------------------------------------------------------
`define APB_ADDR_WIDTH  8
`define APB_DATA_WIDTH  32

`endif

/* common/alu_pkg.sv */
`default_nettype none
`include "alu_macros.svh"

package alu_pkg;

  // Opcodes as written by the host into the control word
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    OP_NOT  = 4'h0,
    OP_AND  = 4'h1,
    OP_OR   = 4'h2,
    OP_XOR  = 4'h3,
    OP_ADD  = 4'h4,
    OP_SUB  = 4'h5,
    OP_NAND = 4'h6,
    OP_NOR  = 4'h7,
    OP_XNOR = 4'h8,
    OP_RSH  = 4'h9,
    OP_LSH  = 4'hA,
    OP_RRO  = 4'hB,
    OP_LRO  = 4'hC   // 0xD to 0xF are illegal
  } alu_op_e;

  typedef enum logic [1:0] {
    UNIT_LOGIC,
    UNIT_ARITH,
    UNIT_SHIFT,
    UNIT_NONE
  } alu_unit_e;

  typedef enum logic [1:0] {
    LOGIC_AND,
    LOGIC_OR,
    LOGIC_XOR
  } alu_logic_e;

  typedef enum logic [1:0] {
    SHIFT_RSH,
    SHIFT_LSH,
    SHIFT_RRO,
    SHIFT_LRO
  } alu_shift_e;

  typedef struct packed {
    alu_unit_e  unit;        // Output select
    alu_logic_e logic_fn;
    alu_shift_e shift_mode;
    logic       invert_b;    // SUB only
    logic       force_cin;   // SUB only
    logic       pass_a;      // NOT only
    logic       invert_out;  // NOT, NAND, NOR, XNOR
    logic       illegal;
  } alu_ctrl_t;

  typedef struct packed {
    logic                       valid;
    alu_op_e                    op;
    logic [`ALU_WORD_WIDTH-1:0] a;
    logic [`ALU_WORD_WIDTH-1:0] b;
    logic                       cin;
  } alu_req_t;

  typedef struct packed {
    logic                       valid;
    logic [`ALU_WORD_WIDTH-1:0] out;
    logic                       cout;
    logic                       illegal;
  } alu_res_t;

endpackage

`default_nettype wire

/* common/apb_pkg.sv */
`default_nettype none
`include "alu_macros.svh"

package apb_pkg;

  typedef struct packed {
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pready;   // Tied high, no wait states
    logic                       pslverr;
  } apb_rsp_t;

  // Register map of the ALU block
  typedef enum logic [`APB_ADDR_WIDTH-1:0] {
    REG_A      = 8'h00,
    REG_B      = 8'h04,
    REG_CTRL   = 8'h08,  // Opcode 3:0, carry-in 4
    REG_RESULT = 8'h0C,  // Result 15:0, carry-out 16
    REG_STATUS = 8'h10   // Done 0, illegal 1
  } apb_reg_e;

endpackage

`default_nettype wire

/* alu/alu_logic_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "alu_macros.svh"

module alu_logic_unit #(
  parameter int REG_WIDTH = `ALU_WORD_WIDTH
) (
  input  wire logic [REG_WIDTH-1:0] a_i,
  input  wire logic [REG_WIDTH-1:0] b_i,
  input  wire logic                 cin_i,
  input  wire alu_pkg::alu_ctrl_t   ctrl_i,
  output logic [REG_WIDTH-1:0]      out_o,
  output logic                      cout_o
);

  import alu_pkg::*;

  logic [REG_WIDTH-1:0] b_adj;
  logic                 carry_in;
  logic [REG_WIDTH:0]   sum;
  logic [REG_WIDTH-1:0] bitwise;
  logic [REG_WIDTH-1:0] logic_res;

  // --------------------------------------------------------------------
  // Adder
  // --------------------------------------------------------------------
  assign b_adj    = ctrl_i.invert_b ? ~b_i : b_i;  // Two's complement for SUB
  assign carry_in = ctrl_i.force_cin | cin_i;
  assign sum      = {1'b0, a_i} + {1'b0, b_adj} + {{REG_WIDTH{1'b0}}, carry_in};

  // --------------------------------------------------------------------
  // Bitwise functions
  // --------------------------------------------------------------------
  always_comb begin
    case (ctrl_i.logic_fn)
      LOGIC_AND: bitwise = a_i & b_i;
      LOGIC_OR:  bitwise = a_i | b_i;
      LOGIC_XOR: bitwise = a_i ^ b_i;
      default:   bitwise = '0;
    endcase
  end

  assign logic_res = ctrl_i.pass_a ? a_i : bitwise;

  always_comb begin
    if (ctrl_i.unit == UNIT_ARITH) begin
      out_o  = sum[REG_WIDTH-1:0];
      cout_o = sum[REG_WIDTH];  // Carry out of the top bit
    end else begin
      out_o  = ctrl_i.invert_out ? ~logic_res : logic_res;
      cout_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* alu/alu_shifter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "alu_macros.svh"

module alu_shifter #(
  parameter int REG_WIDTH = `ALU_WORD_WIDTH
) (
  input  wire logic [REG_WIDTH-1:0]        a_i,
  input  wire logic [`ALU_SHAMT_WIDTH-1:0] shamt_i,
  input  wire alu_pkg::alu_shift_e         mode_i,
  output logic [REG_WIDTH-1:0]             out_o
);

  import alu_pkg::*;

  // Stage k moves the word by 2**k when shamt_i[k] is set
  logic [REG_WIDTH-1:0] stage [`ALU_SHAMT_WIDTH+1];

  assign stage[0] = a_i;

  for (genvar k = 0; k < `ALU_SHAMT_WIDTH; k++) begin : g_stage
    localparam int SH = 2 ** k;

    logic [REG_WIDTH-1:0] moved;

    always_comb begin
      case (mode_i)
        SHIFT_RSH: moved = {{SH{1'b0}}, stage[k][REG_WIDTH-1:SH]};         // Zero fill
        SHIFT_LSH: moved = {stage[k][REG_WIDTH-SH-1:0], {SH{1'b0}}};
        SHIFT_RRO: moved = {stage[k][SH-1:0], stage[k][REG_WIDTH-1:SH]};   // Wrap low bits
        default:   moved = {stage[k][REG_WIDTH-SH-1:0],
                            stage[k][REG_WIDTH-1:REG_WIDTH-SH]};           // LRO
      endcase
    end

    assign stage[k+1] = shamt_i[k] ? moved : stage[k];
  end

  assign out_o = stage[`ALU_SHAMT_WIDTH];

endmodule

`default_nettype wire

/* alu/alu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "alu_macros.svh"

module alu #(
  parameter int REG_WIDTH = `ALU_WORD_WIDTH
) (
  input  wire logic              clk,
  input  wire logic              rst_n_i,
  input  wire alu_pkg::alu_req_t req_i,
  output alu_pkg::alu_res_t      res_o
);

  import alu_pkg::*;

  alu_ctrl_t            ctrl;
  logic [REG_WIDTH-1:0] lu_out;
  logic                 lu_cout;
  logic [REG_WIDTH-1:0] sh_out;
  logic [REG_WIDTH-1:0] unit_out;
  logic                 unit_cout;

  logic                 valid_q;
  logic [REG_WIDTH-1:0] out_q;
  logic                 cout_q;
  logic                 illegal_q;

  // --------------------------------------------------------------------
  // Opcode decode
  // --------------------------------------------------------------------
  // Fields: unit, logic fn, shift mode, inv_b, force_cin, pass_a, inv_out, illegal
  always_comb begin
    case (req_i.op)
      OP_NOT:  ctrl = '{UNIT_LOGIC, LOGIC_AND, SHIFT_RSH, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
      OP_AND:  ctrl = '{UNIT_LOGIC, LOGIC_AND, SHIFT_RSH, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_OR:   ctrl = '{UNIT_LOGIC, LOGIC_OR,  SHIFT_RSH, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_XOR:  ctrl = '{UNIT_LOGIC, LOGIC_XOR, SHIFT_RSH, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_ADD:  ctrl = '{UNIT_ARITH, LOGIC_AND, SHIFT_RSH, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_SUB:  ctrl = '{UNIT_ARITH, LOGIC_AND, SHIFT_RSH, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
      OP_NAND: ctrl = '{UNIT_LOGIC, LOGIC_AND, SHIFT_RSH, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
      OP_NOR:  ctrl = '{UNIT_LOGIC, LOGIC_OR,  SHIFT_RSH, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
      OP_XNOR: ctrl = '{UNIT_LOGIC, LOGIC_XOR, SHIFT_RSH, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
      OP_RSH:  ctrl = '{UNIT_SHIFT, LOGIC_AND, SHIFT_RSH, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_LSH:  ctrl = '{UNIT_SHIFT, LOGIC_AND, SHIFT_LSH, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_RRO:  ctrl = '{UNIT_SHIFT, LOGIC_AND, SHIFT_RRO, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_LRO:  ctrl = '{UNIT_SHIFT, LOGIC_AND, SHIFT_LRO, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      default: ctrl = '{UNIT_NONE,  LOGIC_AND, SHIFT_RSH, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    endcase
  end

  alu_logic_unit #(
    .REG_WIDTH(REG_WIDTH)
  ) u_logic_unit (
    .a_i    (req_i.a),
    .b_i    (req_i.b),
    .cin_i  (req_i.cin),
    .ctrl_i (ctrl),
    .out_o  (lu_out),
    .cout_o (lu_cout)
  );

  alu_shifter #(
    .REG_WIDTH(REG_WIDTH)
  ) u_shifter (
    .a_i     (req_i.a),
    .shamt_i (req_i.b[`ALU_SHAMT_WIDTH-1:0]),  // Low bits of B
    .mode_i  (ctrl.shift_mode),
    .out_o   (sh_out)
  );

  always_comb begin
    case (ctrl.unit)
      UNIT_LOGIC, UNIT_ARITH: begin
        unit_out  = lu_out;
        unit_cout = lu_cout;
      end
      UNIT_SHIFT: begin
        unit_out  = sh_out;
        unit_cout = 1'b0;  // Shifts never carry
      end
      default: begin
        unit_out  = '0;
        unit_cout = 1'b0;
      end
    endcase
  end

  // --------------------------------------------------------------------
  // Output register stage
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;  // One cycle behind the request
    end
  end

  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      out_q     <= unit_out;
      cout_q    <= unit_cout;
      illegal_q <= ctrl.illegal;
    end
  end

  assign res_o = '{valid: valid_q, out: out_q, cout: cout_q, illegal: illegal_q};

endmodule

`default_nettype wire

/* verilog/alu_apb_regs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "alu_macros.svh"

module alu_apb_regs (
  input  wire logic              clk,
  input  wire logic              rst_n_i,
  input  wire apb_pkg::apb_req_t apb_req_i,
  output apb_pkg::apb_rsp_t      apb_rsp_o,
  output alu_pkg::alu_req_t      alu_req_o,
  input  wire alu_pkg::alu_res_t alu_res_i
);

  import apb_pkg::*;
  import alu_pkg::*;

  apb_reg_e                   reg_sel;
  logic                       access;
  logic                       addr_hit;
  logic                       read_only;
  logic                       slv_err;
  logic                       wr_en;
  logic                       wr_ctrl;
  logic [`APB_DATA_WIDTH-1:0] rdata;

  logic [`ALU_WORD_WIDTH-1:0] a_q;
  logic [`ALU_WORD_WIDTH-1:0] b_q;
  logic [`ALU_OP_WIDTH-1:0]   op_q;
  logic                       cin_q;
  logic                       launch_q;
  logic [`ALU_WORD_WIDTH-1:0] result_q;
  logic                       cout_q;
  logic                       done_q;
  logic                       illegal_q;

  // --------------------------------------------------------------------
  // Access decode and read mux
  // --------------------------------------------------------------------
  assign reg_sel = apb_reg_e'(apb_req_i.paddr);
  assign access  = apb_req_i.psel & apb_req_i.penable;  // Access phase only

  always_comb begin
    addr_hit  = 1'b1;
    read_only = 1'b0;
    rdata     = '0;
    case (reg_sel)
      REG_A:    rdata = `APB_DATA_WIDTH'(a_q);
      REG_B:    rdata = `APB_DATA_WIDTH'(b_q);
      REG_CTRL: rdata = `APB_DATA_WIDTH'({cin_q, op_q});
      REG_RESULT: begin
        read_only = 1'b1;
        rdata     = `APB_DATA_WIDTH'({cout_q, result_q});
      end
      REG_STATUS: begin
        read_only = 1'b1;
        rdata     = `APB_DATA_WIDTH'({illegal_q, done_q});
      end
      default: addr_hit = 1'b0;  // Unmapped offset
    endcase
  end

  assign slv_err = ~addr_hit | (apb_req_i.pwrite & read_only);
  assign wr_en   = access & apb_req_i.pwrite & ~slv_err;
  assign wr_ctrl = wr_en & (reg_sel == REG_CTRL);

  assign apb_rsp_o.prdata  = (access & ~apb_req_i.pwrite & ~slv_err) ? rdata : '0;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access & slv_err;

  // --------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      a_q       <= '0;
      b_q       <= '0;
      op_q      <= '0;
      cin_q     <= 1'b0;
      launch_q  <= 1'b0;
      result_q  <= '0;
      cout_q    <= 1'b0;
      done_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      launch_q <= wr_ctrl;  // One-cycle request pulse
      if (wr_en) begin
        case (reg_sel)
          REG_A: a_q <= apb_req_i.pwdata[`ALU_WORD_WIDTH-1:0];
          REG_B: b_q <= apb_req_i.pwdata[`ALU_WORD_WIDTH-1:0];
          REG_CTRL: begin
            op_q  <= apb_req_i.pwdata[`ALU_OP_WIDTH-1:0];
            cin_q <= apb_req_i.pwdata[`ALU_OP_WIDTH];
          end
          default: ;
        endcase
      end
      if (alu_res_i.valid) begin
        result_q  <= alu_res_i.out;
        cout_q    <= alu_res_i.cout;
        illegal_q <= alu_res_i.illegal;
        done_q    <= 1'b1;
      end
      // A new launch wins over a result landing on the same edge
      if (wr_ctrl) begin
        done_q <= 1'b0;
      end
    end
  end

  assign alu_req_o = '{valid: launch_q, op: alu_op_e'(op_q), a: a_q, b: b_q, cin: cin_q};

endmodule

`default_nettype wire

/* verilog/alu_apb_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "alu_macros.svh"

module alu_apb_top (
  input  wire logic              clk,
  input  wire logic              rst_n_i,
  input  wire apb_pkg::apb_req_t apb_req_i,
  output apb_pkg::apb_rsp_t      apb_rsp_o
);

  import alu_pkg::*;

  alu_req_t alu_req;  // Launch from the register block
  alu_res_t alu_res;  // Registered ALU result

  alu_apb_regs u_regs (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .alu_req_o (alu_req),
    .alu_res_i (alu_res)
  );

  alu #(
    .REG_WIDTH(`ALU_WORD_WIDTH)
  ) u_alu (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (alu_req),
    .res_o   (alu_res)
  );

endmodule

`default_nettype wire

/* verification/alu_apb_checker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "alu_macros.svh"

module alu_apb_checker (
  input  wire logic                       clk,
  input  wire logic                       rst_n_i,
  input  wire apb_pkg::apb_req_t          apb_req_i,
  input  wire apb_pkg::apb_rsp_t          apb_rsp_i,
  input  wire logic                       row_check_i,   // Table row expectations valid
  input  wire logic [`ALU_WORD_WIDTH:0]   row_result_i,  // {cout, out}
  input  wire logic                       row_illegal_i,
  output logic [31:0]                     err_count_o
);

  import apb_pkg::*;
  import alu_pkg::*;

  logic [`ALU_WORD_WIDTH-1:0] a_m;
  logic [`ALU_WORD_WIDTH-1:0] b_m;
  logic [4:0]                 ctrl_m;    // {cin, op}
  logic [`ALU_WORD_WIDTH+1:0] pend_m;    // {illegal, cout, out} of the launched op
  logic [`ALU_WORD_WIDTH:0]   result_m;
  logic                       illegal_m;
  logic                       done_m;
  logic                       launch_m;
  logic                       valid_m;
  logic                       access;
  logic                       mapped;
  logic                       exp_err;
  logic [`APB_DATA_WIDTH-1:0] exp_data;
  int                         errors = 0;

  // ----------------------------------------------------------------------
  // Reference model of one ALU operation, {illegal, cout, out}
  // ----------------------------------------------------------------------
  function automatic logic [17:0] expect_op(input logic [3:0]  op,
                                            input logic [15:0] a,
                                            input logic [15:0] b,
                                            input logic        cin);
    logic [31:0] twice;
    logic [16:0] sum;
    logic [17:0] res;
    twice = {a, a};  // Rotates read a window of the doubled word
    sum   = '0;
    res   = '0;
    case (op)
      OP_NOT:  res = {2'b00, ~a};
      OP_AND:  res = {2'b00, a & b};
      OP_OR:   res = {2'b00, a | b};
      OP_XOR:  res = {2'b00, a ^ b};
      OP_ADD: begin
        sum = {1'b0, a} + {1'b0, b} + 17'(cin);
        res = {1'b0, sum};
      end
      OP_SUB: begin
        sum = {1'b0, a} + {1'b0, ~b} + 17'd1;  // Carry-in ignored
        res = {1'b0, sum};
      end
      OP_NAND: res = {2'b00, ~(a & b)};
      OP_NOR:  res = {2'b00, ~(a | b)};
      OP_XNOR: res = {2'b00, ~(a ^ b)};
      OP_RSH:  res = {2'b00, a >> b[3:0]};
      OP_LSH:  res = {2'b00, a << b[3:0]};
      OP_RRO: begin
        twice = twice >> b[3:0];
        res   = {2'b00, twice[15:0]};
      end
      OP_LRO: begin
        twice = twice << b[3:0];
        res   = {2'b00, twice[31:16]};
      end
      default: res = {1'b1, 17'h0};  // 0xD to 0xF
    endcase
    return res;
  endfunction

  assign access = apb_req_i.psel & apb_req_i.penable;

  always_comb begin
    mapped   = 1'b1;
    exp_data = '0;
    case (apb_req_i.paddr)
      REG_A:      exp_data = 32'(a_m);
      REG_B:      exp_data = 32'(b_m);
      REG_CTRL:   exp_data = 32'(ctrl_m);
      REG_RESULT: exp_data = 32'(result_m);
      REG_STATUS: exp_data = 32'({illegal_m, done_m});
      default:    mapped = 1'b0;
    endcase
    exp_err = ~mapped | (apb_req_i.pwrite &
              ((apb_req_i.paddr == REG_RESULT) | (apb_req_i.paddr == REG_STATUS)));
  end

  // ----------------------------------------------------------------------
  // Register mirror and compares at each access edge
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (!rst_n_i) begin
      a_m       <= '0;
      b_m       <= '0;
      ctrl_m    <= '0;
      pend_m    <= '0;
      result_m  <= '0;
      illegal_m <= 1'b0;
      done_m    <= 1'b0;
      launch_m  <= 1'b0;
      valid_m   <= 1'b0;
    end else begin
      launch_m <= 1'b0;
      valid_m  <= launch_m;  // Result lands two edges after the CTRL write
      if (valid_m) begin
        result_m  <= pend_m[16:0];
        illegal_m <= pend_m[17];
        done_m    <= 1'b1;
      end
      if (access) begin
        if (apb_rsp_i.pready !== 1'b1) begin
          $display("Error: pready was not high in an access cycle at 0x%02h",
                   apb_req_i.paddr);
          errors = errors + 1;
        end
        if (apb_rsp_i.pslverr !== exp_err) begin
          $display("%s pslverr on %s of address 0x%02h",
                   exp_err ? "Missing" : "Unexpected",
                   apb_req_i.pwrite ? "write" : "read", apb_req_i.paddr);
          errors = errors + 1;
        end
        if (apb_req_i.pwrite && !exp_err) begin
          case (apb_req_i.paddr)
            REG_A: a_m <= apb_req_i.pwdata[15:0];
            REG_B: b_m <= apb_req_i.pwdata[15:0];
            REG_CTRL: begin
              ctrl_m   <= apb_req_i.pwdata[4:0];
              pend_m   <= expect_op(apb_req_i.pwdata[3:0], a_m, b_m, apb_req_i.pwdata[4]);
              launch_m <= 1'b1;
              done_m   <= 1'b0;
            end
            default: ;
          endcase
        end else if (!apb_req_i.pwrite) begin
          if (apb_rsp_i.prdata !== exp_data) begin
            $display("Error: prdata at 0x%02h expected 0x%08h actual 0x%08h",
                     apb_req_i.paddr, exp_data, apb_rsp_i.prdata);
            errors = errors + 1;
          end
          if (row_check_i && apb_req_i.paddr == REG_RESULT &&
              apb_rsp_i.prdata !== 32'(row_result_i)) begin
            $display("Error: prdata (table RESULT) expected 0x%08h actual 0x%08h",
                     32'(row_result_i), apb_rsp_i.prdata);
            errors = errors + 1;
          end
          if (row_check_i && apb_req_i.paddr == REG_STATUS && done_m &&
              apb_rsp_i.prdata[1] !== row_illegal_i) begin
            $display("Error: prdata[1] (table illegal) expected 0x%h actual 0x%h",
                     row_illegal_i, apb_rsp_i.prdata[1]);
            errors = errors + 1;
          end
        end
      end
    end
  end

  assign err_count_o = errors;

endmodule

`default_nettype wire

/* verification/tb_alu_apb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "alu_macros.svh"

module tb_alu_apb;

  import apb_pkg::*;
  import alu_pkg::*;

  localparam int NUM_DIRECTED = 25;
  localparam int NUM_RANDOM   = 40;
  localparam int CYCLE_LIMIT  = (NUM_DIRECTED + NUM_RANDOM) * 12 + 200;

  typedef struct packed {
    logic [3:0]  op;
    logic [15:0] a;
    logic [15:0] b;
    logic        cin;
    logic [15:0] exp_out;
    logic        exp_cout;
    logic        exp_illegal;
  } row_t;

  logic        clk;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        row_check;
  logic [16:0] row_result;
  logic        row_illegal;
  logic [31:0] err_count;
  logic [31:0] lcg_state;
  int          cycle_cnt = 0;

  // op, a, b, cin, expected out, expected cout, expected illegal
  row_t rows [NUM_DIRECTED] = '{
    '{OP_NOT,  16'h1234, 16'h0000, 1'b0, 16'hEDCB, 1'b0, 1'b0},
    '{OP_AND,  16'hF0F0, 16'h3C3C, 1'b0, 16'h3030, 1'b0, 1'b0},
    '{OP_OR,   16'hF0F0, 16'h3C3C, 1'b0, 16'hFCFC, 1'b0, 1'b0},
    '{OP_XOR,  16'hF0F0, 16'h3C3C, 1'b0, 16'hCCCC, 1'b0, 1'b0},
    '{OP_NAND, 16'hF0F0, 16'h3C3C, 1'b0, 16'hCFCF, 1'b0, 1'b0},
    '{OP_NOR,  16'hF0F0, 16'h3C3C, 1'b0, 16'h0303, 1'b0, 1'b0},
    '{OP_XNOR, 16'hF0F0, 16'h3C3C, 1'b0, 16'h3333, 1'b0, 1'b0},
    '{OP_ADD,  16'h1234, 16'h4321, 1'b1, 16'h5556, 1'b0, 1'b0},
    '{OP_ADD,  16'hFFFF, 16'h0001, 1'b0, 16'h0000, 1'b1, 1'b0},  // Wraps with carry
    '{OP_SUB,  16'h0005, 16'h0003, 1'b1, 16'h0002, 1'b1, 1'b0},
    '{OP_SUB,  16'h0003, 16'h0005, 1'b0, 16'hFFFE, 1'b0, 1'b0},  // Borrow
    '{OP_SUB,  16'h7777, 16'h7777, 1'b0, 16'h0000, 1'b1, 1'b0},
    '{OP_RSH,  16'h8001, 16'h0010, 1'b0, 16'h8001, 1'b0, 1'b0},  // Amount 0
    '{OP_RSH,  16'h8001, 16'h000F, 1'b0, 16'h0001, 1'b0, 1'b0},
    '{OP_LSH,  16'h8001, 16'h0004, 1'b0, 16'h0010, 1'b0, 1'b0},
    '{OP_LSH,  16'h8001, 16'h000F, 1'b0, 16'h8000, 1'b0, 1'b0},
    '{OP_RRO,  16'h1234, 16'h0004, 1'b0, 16'h4123, 1'b0, 1'b0},
    '{OP_RRO,  16'h8001, 16'h000F, 1'b0, 16'h0003, 1'b0, 1'b0},
    '{OP_LRO,  16'h1234, 16'h0004, 1'b0, 16'h2341, 1'b0, 1'b0},
    '{OP_LRO,  16'h8001, 16'h000F, 1'b0, 16'hC000, 1'b0, 1'b0},
    '{4'hD,    16'h1234, 16'h0001, 1'b1, 16'h0000, 1'b0, 1'b1},
    '{OP_ADD,  16'h0001, 16'h0001, 1'b0, 16'h0002, 1'b0, 1'b0},  // Clears illegal
    '{4'hE,    16'hFFFF, 16'hFFFF, 1'b0, 16'h0000, 1'b0, 1'b1},
    '{4'hF,    16'hAAAA, 16'h5555, 1'b1, 16'h0000, 1'b0, 1'b1},
    '{OP_XOR,  16'hAAAA, 16'hFFFF, 1'b0, 16'h5555, 1'b0, 1'b0}
  };

  alu_apb_top alu_apb_top_i (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  alu_apb_checker alu_apb_checker_i (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .apb_req_i     (apb_req),
    .apb_rsp_i     (apb_rsp),
    .row_check_i   (row_check),
    .row_result_i  (row_result),
    .row_illegal_i (row_illegal),
    .err_count_o   (err_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Errors found");
    $finish;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // ----------------------------------------------------------------------
  // APB transfers with a setup and an access cycle and no wait states
  // ----------------------------------------------------------------------
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    apb_req.penable <= 1'b1;  // Completes at the next edge
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;  // Mid access cycle
  endtask

  task automatic bus_idle;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic read_all_regs;
    logic [31:0] data;
    apb_read(REG_A, data);
    apb_read(REG_B, data);
    apb_read(REG_CTRL, data);
    apb_read(REG_RESULT, data);
    apb_read(REG_STATUS, data);
    apb_read(8'h20, data);  // Unmapped
  endtask

  task automatic run_row(input row_t r, input logic checked);
    logic [31:0] status;
    logic [31:0] result;
    apb_write(REG_A, 32'(r.a));
    // Previous row's last read has completed by now
    row_check   <= checked;
    row_result  <= {r.exp_cout, r.exp_out};
    row_illegal <= r.exp_illegal;
    apb_write(REG_B, 32'(r.b));
    apb_write(REG_CTRL, {27'h0, r.cin, r.op});
    status = '0;
    while (!status[0]) begin
      apb_read(REG_STATUS, status);  // Poll done
    end
    apb_read(REG_RESULT, result);
  endtask

  initial begin : stimulus
    row_t r;
    rst_n       = 1'b0;
    apb_req     = '0;
    row_check   = 1'b0;
    row_result  = '0;
    row_illegal = 1'b0;
    lcg_state   = 32'd56201;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    read_all_regs();  // All zero after reset

    for (int i = 0; i < NUM_DIRECTED; i++) begin
      run_row(rows[i], 1'b1);
    end

    // Erroring writes must leave every register as it was
    apb_write(8'h14, 32'h0000_5A5A);
    apb_write(8'h02, 32'h0000_1234);
    apb_write(REG_RESULT, 32'h0001_FFFF);
    apb_write(REG_STATUS, 32'h0000_0003);
    read_all_regs();

    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = '0;
      lcg_state = next_rand(lcg_state);
      r.op      = lcg_state[27:24];
      r.cin     = lcg_state[30];
      lcg_state = next_rand(lcg_state);
      r.a       = lcg_state[31:16];
      lcg_state = next_rand(lcg_state);
      r.b       = lcg_state[31:16];
      run_row(r, 1'b0);  // Checker model supplies the expectation
    end

    bus_idle();
    repeat (2) @(posedge clk);
    $display("Run complete with %0d errors", err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/alu_pkg.sv
common/apb_pkg.sv
alu/alu_logic_unit.sv
alu/alu_shifter.sv
alu/alu.sv
verilog/alu_apb_regs.sv
verilog/alu_apb_top.sv
verification/alu_apb_checker.sv
verification/tb_alu_apb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ALU APB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_alu_apb -f compile.f -o sim_alu_apb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_alu_apb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
  exit 0
else
  exit 1
fi
